//--- src/nes_glue_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and constants for the NES host glue, fixed for MiST-style hosts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef NES_GLUE_CONFIG_SVH
`define NES_GLUE_CONFIG_SVH

// Memory side
`define NES_ADDR_W 22
`define JOY_W 8

// PPU slot of the four-phase memory sequence
`define MEM_PHASE_PPU 3

// Reset countdown after a download, in non-busy clocks
`define DL_RESET_CYCLES 255

// SD block address
`define LBA_W 32

// Save-RAM window, 256 KiB
`define SRAM_ADDR_W 18

// Sector count taken from image size bits 20..9
`define SAV_SIZE_W 12

`endif

//--- src/nes_io_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Controller and memory port types, mem_port_t is 32 bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "nes_glue_config.svh"

package nes_io_pkg;

	// CPU side memory port
	typedef struct packed {
		logic [`NES_ADDR_W-1:0] addr;
		logic [7:0]             wdata;
		logic                   rd;     // Read strobe
		logic                   wr;     // Write strobe
	} mem_port_t;

	// One loader write, wr is a single-cycle pulse
	typedef struct packed {
		logic [`NES_ADDR_W-1:0] addr;
		logic [7:0]             data;
		logic                   wr;
	} loader_wr_t;

	// Host joystick bytes
	// Bit order is the host's, not the NES shift order
	typedef struct packed {
		logic [`JOY_W-1:0] a;   // Port A, first controller
		logic [`JOY_W-1:0] b;   // Port B
	} joy_pair_t;

endpackage

`default_nettype wire

//--- src/nes_save_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Backup state and SD / save-RAM request types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "nes_glue_config.svh"

package nes_save_pkg;

	typedef enum logic [0:0] {
		BK_IDLE = 1'b0,
		BK_XFER = 1'b1  // Sector transfer running
	} bk_state_e;

	// Sector request to the host, rd and wr are mutually exclusive
	typedef struct packed {
		logic [`LBA_W-1:0] lba;
		logic              rd;
		logic              wr;
	} sd_req_t;

	// Save-RAM byte request, ended by an ack toggle
	typedef struct packed {
		logic [`SRAM_ADDR_W-1:0] addr;
		logic                    we;
		logic                    oe;
	} sram_req_t;

endpackage

`default_nettype wire

//--- src/reset_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core reset source, relies on power-up register init for the hold
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "nes_glue_config.svh"

module reset_sequencer (
	input  wire  clk,
	input  wire  downloading,
	input  wire  loader_busy,
	input  wire  loader_fail,
	input  wire  reset_button,
	input  wire  menu_reset,
	output logic reset_nes
);

	localparam int CNT_W = $clog2(`DL_RESET_CYCLES + 1);

	// Held from power-up until the first download is seen
	logic init_hold = 1'b1;

	logic [CNT_W-1:0] dl_cnt = '0;
	logic             dl_reset;

	always_ff @(posedge clk) begin
		if (downloading)
			init_hold <= 1'b0;
	end

	// Reloaded through the download, counts only while the loader is idle
	always_ff @(posedge clk) begin
		if (downloading) begin
			dl_cnt <= CNT_W'(`DL_RESET_CYCLES);
		end else if (!loader_busy && dl_cnt != '0) begin
			dl_cnt <= dl_cnt - 1'b1;
		end
	end

	assign dl_reset = (dl_cnt != '0);

	// Downloading is ORed in so the first download cycle is covered too
	assign reset_nes = init_hold | downloading | dl_reset | loader_fail |
		reset_button | menu_reset;

endmodule

`default_nettype wire

//--- src/joypad_ports.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two standard pads only, no Power Pad or keyboard merge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "nes_glue_config.svh"

module joypad_ports (
	input  wire                   clk,
	input  wire                   reset_nes,
	input  nes_io_pkg::joy_pair_t joy_raw,
	input  wire                   joy_swap,
	input  wire                   joypad_strobe,
	input  wire [1:0]             joypad_clock,
	output logic [1:0]            joypad_data
);

	// Host order to NES shift order (A, B, Select, Start, Up, Down, Left, Right)
	function automatic logic [`JOY_W-1:0] nes_order(input logic [`JOY_W-1:0] j);
		return {j[0], j[1], j[2], j[3], j[7], j[6], j[5], j[4]};
	endfunction

	nes_io_pkg::joy_pair_t swapped;
	nes_io_pkg::joy_pair_t shift_q;
	logic [1:0]            last_clock;
	logic [1:0]            clk_fall;

	always_comb begin
		swapped.a = joy_swap ? joy_raw.b : joy_raw.a;
		swapped.b = joy_swap ? joy_raw.a : joy_raw.b;
	end

	assign clk_fall = last_clock & ~joypad_clock;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_q    <= '0;
			last_clock <= 2'b00;
		end else begin
			if (joypad_strobe) begin
				shift_q.a <= nes_order(swapped.a);
				shift_q.b <= nes_order(swapped.b);
			end
			// Shift wins over a strobe in the same cycle
			if (clk_fall[0])
				shift_q.a <= {1'b0, shift_q.a[`JOY_W-1:1]};
			if (clk_fall[1])
				shift_q.b <= {1'b0, shift_q.b[`JOY_W-1:1]};
			last_clock <= joypad_clock;
		end
	end

	assign joypad_data = {shift_q.b[0], shift_q.a[0]};  // Port A on bit 0

endmodule

`default_nettype wire

//--- src/loader_write_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Loader writes must be at least four clocks apart, no back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "nes_glue_config.svh"

module loader_write_stage (
	input  wire                    clk,
	input  wire                    downloading,
	input  wire                    loader_busy,
	input  wire [1:0]              mem_phase,
	input  nes_io_pkg::loader_wr_t loader_wr,
	input  nes_io_pkg::mem_port_t  cpu_mem,
	output nes_io_pkg::mem_port_t  mem_b
);

	logic pending = 1'b0;   // Captured, waiting for the PPU phase
	logic wr_q = 1'b0;      // Released strobe, one full phase round

	logic [`NES_ADDR_W-1:0] stage_addr;
	logic [7:0]             stage_data;
	logic [`NES_ADDR_W-1:0] out_addr;
	logic [7:0]             out_data;
	logic                   ppu_phase;
	logic                   loading;

	assign ppu_phase = (mem_phase == 2'(`MEM_PHASE_PPU));
	assign loading   = downloading | loader_busy;

	always_ff @(posedge clk) begin
		if (loader_wr.wr) begin
			stage_addr <= loader_wr.addr;
			stage_data <= loader_wr.data;
		end
		if (ppu_phase) begin
			out_addr <= stage_addr;  // Old capture goes out, new one stays staged
			out_data <= stage_data;
		end
	end

	always_ff @(posedge clk) begin
		if (ppu_phase) begin
			wr_q    <= pending;
			pending <= loader_wr.wr;
		end else if (loader_wr.wr) begin
			pending <= 1'b1;
		end
	end

	// CPU port muxed to the staged write while the loader owns memory
	always_comb begin
		mem_b.addr  = loading ? out_addr : cpu_mem.addr;
		mem_b.wdata = loading ? out_data : cpu_mem.wdata;
		mem_b.rd    = ~loading & cpu_mem.rd;
		mem_b.wr    = wr_q | cpu_mem.wr;
	end

endmodule

`default_nettype wire

//--- src/save_backup_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Battery save over SD, image must be a whole number of 512-byte sectors
// Transfers sav_size+1 sectors, save RAM byte addressing starts at all ones
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "nes_glue_config.svh"

module save_backup_fsm (
	input  wire                     clk,
	input  wire                     reset_nes,
	input  wire                     img_mounted,
	input  wire [31:0]              img_size,
	input  wire                     bk_load,
	input  wire                     bk_save,
	input  wire                     downloading,
	input  wire                     sd_ack,
	input  wire                     sd_buff_wr,
	input  wire                     sd_buff_rd,
	input  wire                     sram_ack,
	output nes_save_pkg::sd_req_t   sd_req,
	output nes_save_pkg::sram_req_t sram_req,
	output logic                    bk_ena
);

	nes_save_pkg::bk_state_e bk_state;

	logic                   bk_loading;     // Direction of the running transfer
	logic [`SAV_SIZE_W-1:0] sav_size;       // Last sector index

	// Previous-cycle copies for edge detection
	logic img_mounted_q;
	logic downloading_q;
	logic bk_load_q;
	logic bk_save_q;
	logic sd_ack_q;
	logic sram_ack_q;

	logic trigger;
	logic sector_end;

	always_ff @(posedge clk) begin
		img_mounted_q <= img_mounted;
		downloading_q <= downloading;
		bk_load_q     <= bk_load;
		bk_save_q     <= bk_save;
		sd_ack_q      <= sd_ack;
		sram_ack_q    <= sram_ack;
	end

	assign trigger    = (~bk_load_q & bk_load) | (~bk_save_q & bk_save);
	assign sector_end = sd_ack_q & ~sd_ack;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			bk_ena       <= 1'b0;
			bk_state     <= nes_save_pkg::BK_IDLE;
			bk_loading   <= 1'b0;
			sd_req.rd    <= 1'b0;
			sd_req.wr    <= 1'b0;
			sram_req.we  <= 1'b0;
			sram_req.oe  <= 1'b0;
		end else begin
			// Any ack toggle ends the save-RAM request
			if (sram_ack_q ^ sram_ack) begin
				sram_req.we <= 1'b0;
				sram_req.oe <= 1'b0;
			end

			if (~img_mounted_q & img_mounted) begin
				bk_ena <= |img_size;
				if (|img_size)
					sav_size <= img_size[`SAV_SIZE_W+8:9];
			end
			if (~downloading_q & downloading)
				bk_ena <= 1'b0;     // New game, old save no longer valid

			if (~sd_ack_q & sd_ack) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			case (bk_state)
				nes_save_pkg::BK_IDLE: begin
					if (bk_ena && trigger) begin
						bk_state      <= nes_save_pkg::BK_XFER;
						bk_loading    <= bk_load;
						sd_req.lba    <= '0;
						sd_req.rd     <= bk_load;
						sd_req.wr     <= ~bk_load;
						sram_req.addr <= '1;
					end
				end
				nes_save_pkg::BK_XFER: begin
					if (sector_end) begin
						if (sd_req.lba[`SAV_SIZE_W-1:0] == sav_size) begin
							bk_state   <= nes_save_pkg::BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_req.lba <= sd_req.lba + 1'b1;
							sd_req.rd  <= bk_loading;   // Next sector, same direction
							sd_req.wr  <= ~bk_loading;
						end
					end
				end
				default: bk_state <= nes_save_pkg::BK_IDLE;
			endcase

			// Buffer strobes step the save-RAM address, set after the ack clear
			if (sd_buff_wr) begin
				sram_req.we   <= 1'b1;
				sram_req.addr <= sram_req.addr + 1'b1;
			end
			if (sd_buff_rd) begin
				sram_req.oe   <= 1'b1;
				sram_req.addr <= sram_req.addr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/nes_host_glue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board glue around the NES core, single clock domain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module nes_host_glue (
	input  wire                     clk,
	// Host side
	input  nes_io_pkg::joy_pair_t   joy_raw,
	input  wire                     joy_swap,
	input  wire                     downloading,
	input  wire                     loader_busy,
	// Loader side
	input  wire                     loader_fail,
	input  nes_io_pkg::loader_wr_t  loader_wr,
	input  wire                     reset_button,
	input  wire                     menu_reset,
	// Core side
	input  wire [1:0]               mem_phase,
	input  wire                     joypad_strobe,
	input  wire [1:0]               joypad_clock,
	input  nes_io_pkg::mem_port_t   cpu_mem,
	// Backup
	input  wire                     img_mounted,
	input  wire [31:0]              img_size,
	input  wire                     bk_load,
	input  wire                     bk_save,
	input  wire                     sd_ack,
	input  wire                     sd_buff_wr,
	input  wire                     sd_buff_rd,
	input  wire                     sram_ack,
	output logic                    reset_nes,
	output logic [1:0]              joypad_data,
	output nes_io_pkg::mem_port_t   mem_b,      // Muxed CPU port
	output nes_save_pkg::sd_req_t   sd_req,
	output nes_save_pkg::sram_req_t sram_req,
	output logic                    bk_ena
);

	reset_sequencer u_reset (
		.clk          (clk),
		.downloading  (downloading),
		.loader_busy  (loader_busy),
		.loader_fail  (loader_fail),
		.reset_button (reset_button),
		.menu_reset   (menu_reset),
		.reset_nes    (reset_nes)
	);

	joypad_ports u_joypad (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joy_raw       (joy_raw),
		.joy_swap      (joy_swap),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data)
	);

	loader_write_stage u_loader_wr (
		.clk         (clk),
		.downloading (downloading),
		.loader_busy (loader_busy),
		.mem_phase   (mem_phase),
		.loader_wr   (loader_wr),
		.cpu_mem     (cpu_mem),
		.mem_b       (mem_b)
	);

	save_backup_fsm u_backup (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.bk_load     (bk_load),
		.bk_save     (bk_save),
		.downloading (downloading),
		.sd_ack      (sd_ack),
		.sd_buff_wr  (sd_buff_wr),
		.sd_buff_rd  (sd_buff_rd),
		.sram_ack    (sram_ack),
		.sd_req      (sd_req),
		.sram_req    (sram_req),
		.bk_ena      (bk_ena)
	);

endmodule

`default_nettype wire

//--- bench/tb_nes_host_glue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven checks of all four glue functions
// SD host and save RAM are behavioral models, mem_phase free-runs 0..3
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "nes_glue_config.svh"

module tb_nes_host_glue;

	logic clk = 1'b0;
	nes_io_pkg::joy_pair_t   joy_raw;
	nes_io_pkg::loader_wr_t  loader_wr;
	nes_io_pkg::mem_port_t   cpu_mem;
	nes_io_pkg::mem_port_t   mem_b;
	nes_save_pkg::sd_req_t   sd_req;
	nes_save_pkg::sram_req_t sram_req;
	logic joy_swap, downloading, loader_busy, loader_fail, reset_button, menu_reset;
	logic joypad_strobe, img_mounted, bk_load, bk_save;
	logic sd_ack, sd_buff_wr, sd_buff_rd, sram_ack;
	logic [1:0]  mem_phase, joypad_clock, joypad_data;
	logic [31:0] img_size;
	logic        reset_nes, bk_ena;

	// Shared with the SD and save-RAM models
	logic                    xfer_rd = 1'b0;    // Direction expected from the DUT
	logic                    sd_active = 1'b0;
	int                      strobes = 0;       // Buffer strobes per sector
	int                      sectors_seen = 0;
	int                      sram_seen = 0;
	logic [`LBA_W-1:0]       next_lba = '0;
	logic [`SRAM_ADDR_W-1:0] sram_exp_addr = '0;

	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	integer seed = 32'h23daef74;

	// Joypad rows: host byte A, host byte B, swap (rows 4 and 5 are random)
	logic [7:0] pad_a_tab [6] = '{8'h01, 8'hA5, 8'hFF, 8'h12, 8'h00, 8'h00};
	logic [7:0] pad_b_tab [6] = '{8'h80, 8'h3C, 8'h00, 8'hE7, 8'h00, 8'h00};
	logic       pad_swap_tab [6] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
	// Loader rows: address and data
	logic [`NES_ADDR_W-1:0] ld_addr_tab [3] = '{22'h000000, 22'h3FFFFF, 22'h123456};
	logic [7:0]             ld_data_tab [3] = '{8'h4E, 8'hA1, 8'h1A};
	// Backup rows: image size, load, strobes per sector, sectors expected
	logic [31:0] bk_size_tab [4] = '{32'h200, 32'h200, 32'h400, 32'h100};
	logic        bk_load_tab [4] = '{1'b0, 1'b1, 1'b0, 1'b1};
	int          bk_strobe_tab [4] = '{3, 3, 2, 4};
	int          bk_sector_tab [4] = '{2, 2, 3, 1};

	nes_host_glue UUT (.*);

	always #10 clk = ~clk;

	// Four-phase memory sequence of the core
	always @(posedge clk) begin
		#2 mem_phase = mem_phase + 2'd1;
	end

	task automatic next_cycle;
		@(posedge clk);
		#2;
	endtask

	task automatic report_error(input string msg);
		$display("FAIL t=%0t %s", $time, msg);
		errors++;
	endtask

	task automatic abort_run(input string what);
		$display("Timeout while waiting for %s, run stopped", what);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_errors) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - test_errors);
		end else begin
			$display("test %s: passed", name);
		end
		test_errors = errors;
	endtask

	// Host bit i of the low nibble lands on 7-i, host bit 7-i on 3-i
	function automatic logic [7:0] to_shift_order(input logic [7:0] host);
		logic [7:0] o;
		for (int i = 0; i < 4; i++) begin
			o[7 - i] = host[i];
			o[3 - i] = host[7 - i];
		end
		return o;
	endfunction

	task automatic pulse_pad_clock(input int port);
		next_cycle();
		joypad_clock[port] = 1'b1;
		next_cycle();
		joypad_clock[port] = 1'b0;
		next_cycle();           // Falling edge seen at this edge
	endtask

	task automatic mount_image(input logic [31:0] size);
		next_cycle();
		img_size = size;
		img_mounted = 1'b1;
		next_cycle();
		img_mounted = 1'b0;
		@(negedge clk);
	endtask

	task automatic trigger_backup(input logic load);
		next_cycle();
		bk_load = load;
		bk_save = ~load;
		next_cycle();
		bk_load = 1'b0;
		bk_save = 1'b0;
	endtask

	task automatic expect_no_request(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (sd_req.rd || sd_req.wr)
				report_error("unexpected SD request");
		end
	endtask

	task automatic wait_reset_release;
		int n;
		n = 0;
		while (reset_nes !== 1'b0) begin
			if (n > 400)
				abort_run("reset release");
			@(negedge clk);
			n++;
		end
	endtask

	// SD host, one sector per request
	always begin : sd_responder
		logic is_rd;
		@(negedge clk);
		if (sd_req.rd || sd_req.wr) begin
			sd_active = 1'b1;
			is_rd = sd_req.rd;
			if (sd_req.rd !== xfer_rd || sd_req.wr !== ~xfer_rd)
				report_error("SD request has the wrong direction");
			if (sd_req.lba !== next_lba)
				report_error($sformatf("SD lba %0d, expected %0d", sd_req.lba, next_lba));
			next_lba = next_lba + 1'b1;
			sectors_seen++;
			repeat (2) @(posedge clk);
			next_cycle();
			sd_ack = 1'b1;
			@(posedge clk);
			@(negedge clk);
			if (sd_req.rd || sd_req.wr)
				report_error("SD request still set after sd_ack rose");
			for (int k = 0; k < strobes; k++) begin
				next_cycle();
				sd_buff_wr = is_rd;     // Sector read fills the buffer
				sd_buff_rd = ~is_rd;
				next_cycle();
				sd_buff_wr = 1'b0;
				sd_buff_rd = 1'b0;
				repeat (4) @(posedge clk);
			end
			next_cycle();
			sd_ack = 1'b0;          // Ends the sector
			sd_active = 1'b0;
		end
	end

	// Save RAM, answers each request with an ack toggle
	always begin : sram_responder
		@(negedge clk);
		if (sram_req.we || sram_req.oe) begin
			sram_seen++;
			sram_exp_addr = sram_exp_addr + 1'b1;
			if (sram_req.we !== xfer_rd || sram_req.oe !== ~xfer_rd)
				report_error("save-RAM request has the wrong strobe");
			if (sram_req.addr !== sram_exp_addr)
				report_error($sformatf("save-RAM addr %h, expected %h",
					sram_req.addr, sram_exp_addr));
			next_cycle();
			sram_ack = ~sram_ack;
			repeat (2) @(negedge clk);
			if (sram_req.we || sram_req.oe)
				report_error("save-RAM request still set after the ack toggle");
		end
	end

	initial begin
		int         nonbusy;
		int         n;
		int         since;
		int         sa;
		int         sb;
		logic       exp_wr;
		logic [1:0] exp_pad;
		logic [7:0] ea;
		logic [7:0] eb;
		logic [31:0] r;

		joy_raw = '0;
		joy_swap = 1'b0;
		downloading = 1'b0;
		loader_busy = 1'b0;
		loader_fail = 1'b0;
		reset_button = 1'b0;
		menu_reset = 1'b0;
		loader_wr = '0;
		cpu_mem = '0;
		mem_phase = 2'd0;
		joypad_strobe = 1'b0;
		joypad_clock = 2'b00;
		img_mounted = 1'b0;
		img_size = '0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		sd_ack = 1'b0;
		sd_buff_wr = 1'b0;
		sd_buff_rd = 1'b0;
		sram_ack = 1'b0;

		// Reset: hold before the first download, then the countdown
		@(negedge clk);
		if (reset_nes !== 1'b1)
			report_error("reset_nes low before the first download");
		next_cycle();
		downloading = 1'b1;
		for (int d = 0; d < 2; d++) begin
			@(negedge clk);
			if (reset_nes !== 1'b1)
				report_error("reset_nes low during downloading");
			next_cycle();
		end
		downloading = 1'b0;
		nonbusy = 0;
		for (int cyc = 0; cyc < `DL_RESET_CYCLES + 30; cyc++) begin
			@(negedge clk);
			if (reset_nes !== (nonbusy < `DL_RESET_CYCLES))
				report_error($sformatf("reset_nes %b after %0d idle cycles", reset_nes, nonbusy));
			if (reset_nes && {bk_ena, sd_req.rd, sd_req.wr, sram_req.we, sram_req.oe,
					joypad_data} !== '0)
				report_error("outputs not cleared during reset");
			if (!loader_busy)
				nonbusy++;
			next_cycle();
			loader_busy = (cyc >= 100 && cyc < 110);  // Stretches the countdown
		end
		for (int s = 0; s < 3; s++) begin
			next_cycle();
			loader_fail = (s == 0);
			reset_button = (s == 1);
			menu_reset = (s == 2);
			@(negedge clk);
			if (reset_nes !== 1'b1)
				report_error($sformatf("reset_nes low with reset source %0d high", s));
			next_cycle();
			{loader_fail, reset_button, menu_reset} = 3'b000;
			@(negedge clk);
			if (reset_nes !== 1'b0)
				report_error($sformatf("reset_nes stuck after reset source %0d", s));
		end
		finish_test("reset");

		for (int i = 4; i < 6; i++) begin
			r = $random(seed);
			pad_a_tab[i] = r[7:0];
			pad_b_tab[i] = r[15:8];
			pad_swap_tab[i] = r[16];
		end
		for (int row = 0; row < 6; row++) begin
			ea = to_shift_order(pad_swap_tab[row] ? pad_b_tab[row] : pad_a_tab[row]);
			eb = to_shift_order(pad_swap_tab[row] ? pad_a_tab[row] : pad_b_tab[row]);
			next_cycle();
			joy_raw.a = pad_a_tab[row];
			joy_raw.b = pad_b_tab[row];
			joy_swap = pad_swap_tab[row];
			joypad_strobe = 1'b1;
			next_cycle();
			joypad_strobe = 1'b0;
			@(negedge clk);
			// Port A shifted nine times first, then port B
			for (int k = 0; k <= 17; k++) begin
				if (k > 0) begin
					pulse_pad_clock(k > 9);
					@(negedge clk);
				end
				sa = (k > 9) ? 9 : k;
				sb = (k > 9) ? k - 9 : 0;
				exp_pad = {sb < 8 ? eb[sb] : 1'b0, sa < 8 ? ea[sa] : 1'b0};
				if (joypad_data !== exp_pad)
					report_error($sformatf("row %0d shifts %0d/%0d joypad_data %b, expected %b",
						row, sa, sb, joypad_data, exp_pad));
			end
		end
		finish_test("joypad");

		next_cycle();
		loader_busy = 1'b1;
		cpu_mem.rd = 1'b1;      // Must be masked while loading
		for (int row = 0; row < 3; row++) begin
			repeat (row + 1) next_cycle();
			loader_wr.addr = ld_addr_tab[row];
			loader_wr.data = ld_data_tab[row];
			loader_wr.wr = 1'b1;
			next_cycle();
			loader_wr.wr = 1'b0;
			since = 0;
			for (int c = 0; c < 12; c++) begin
				@(posedge clk);
				if (since > 0)
					since++;
				else if (mem_phase == 2'(`MEM_PHASE_PPU))
					since = 1;
				@(negedge clk);
				exp_wr = (since >= 1 && since <= 4);
				if (mem_b.wr !== exp_wr || mem_b.rd !== 1'b0)
					report_error($sformatf("row %0d mem_b wr %b rd %b, expected wr %b",
						row, mem_b.wr, mem_b.rd, exp_wr));
				if (exp_wr && (mem_b.addr !== ld_addr_tab[row] ||
						mem_b.wdata !== ld_data_tab[row]))
					report_error($sformatf("row %0d staged write %h/%h", row,
						mem_b.addr, mem_b.wdata));
			end
		end
		next_cycle();
		loader_busy = 1'b0;
		for (int c = 0; c < 8; c++) begin
			next_cycle();
			r = $random(seed);
			cpu_mem = r;
			@(negedge clk);
			if (mem_b !== cpu_mem)
				report_error($sformatf("mem_b %h, cpu_mem %h", mem_b, cpu_mem));
		end
		cpu_mem = '0;
		finish_test("loader_write");

		for (int row = 0; row < 4; row++) begin
			mount_image(bk_size_tab[row]);
			if (bk_ena !== 1'b1)
				report_error($sformatf("bk_ena low after mounting row %0d", row));
			xfer_rd = bk_load_tab[row];
			strobes = bk_strobe_tab[row];
			next_lba = '0;
			sectors_seen = 0;
			sram_seen = 0;
			sram_exp_addr = '1;
			trigger_backup(bk_load_tab[row]);
			n = 0;
			while (sectors_seen < bk_sector_tab[row] || sd_active) begin
				if (n > 3000)
					abort_run("backup transfer");
				@(negedge clk);
				n++;
			end
			expect_no_request(20);
			if (sectors_seen != bk_sector_tab[row] ||
					sram_seen != strobes * bk_sector_tab[row])
				report_error($sformatf("row %0d moved %0d sectors and %0d bytes", row,
					sectors_seen, sram_seen));
		end
		finish_test("backup_xfer");

		sectors_seen = 0;
		mount_image(32'h0);
		if (bk_ena !== 1'b0)
			report_error("bk_ena high after a zero-size mount");
		trigger_backup(1'b0);
		expect_no_request(20);
		mount_image(32'h200);
		if (bk_ena !== 1'b1)
			report_error("bk_ena low after a non-zero mount");
		next_cycle();
		downloading = 1'b1;
		next_cycle();
		@(negedge clk);
		if (bk_ena !== 1'b0)
			report_error("bk_ena high after a download start");
		next_cycle();
		downloading = 1'b0;
		wait_reset_release();
		trigger_backup(1'b1);
		expect_no_request(20);
		if (sectors_seen != 0)
			report_error("sector served while backup disabled");
		finish_test("backup_enable");

		$display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- nes_host_glue.f
+incdir+src
src/nes_io_pkg.sv
src/nes_save_pkg.sv
src/reset_sequencer.sv
src/joypad_ports.sv
src/loader_write_stage.sv
src/save_backup_fsm.sv
src/nes_host_glue.sv
bench/tb_nes_host_glue.sv

//--- Bender.yml
package:
  name: nes_host_glue

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/nes_io_pkg.sv
      - src/nes_save_pkg.sv
      - src/reset_sequencer.sv
      - src/joypad_ports.sv
      - src/loader_write_stage.sv
      - src/save_backup_fsm.sv
      - src/nes_host_glue.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_nes_host_glue.sv
